// ==== design/div_data_pkg.sv ====
/*
 * Data widths, word-level typedefs and constants for the divide unit.
 * Also the raw quotient/remainder struct driven by the iterative core.
 */
package div_data_pkg;

    // datapath width, RV32
    localparam int XLEN = 32;

    // one quotient bit per iteration
    localparam int DIV_CYCLES = XLEN;

    // counter has to reach DIV_CYCLES itself, hence the +1
    localparam int CNT_W = $clog2(DIV_CYCLES + 1);

    // operand / result word
    typedef logic [XLEN-1:0] word_t;

    // iteration counter
    typedef logic [CNT_W-1:0] count_t;

    // architected constants used by the special cases
    localparam word_t WORD_MIN  = {1'b1, {(XLEN-1){1'b0}}};  // most negative value
    localparam word_t WORD_ONES = {XLEN{1'b1}};              // all ones, also -1 signed
    localparam word_t WORD_ZERO = {XLEN{1'b0}};

    // raw core output, both fields are unsigned magnitudes
    typedef struct packed {
        word_t quot;  // raw quotient
        word_t rem;   // raw remainder
    } core_result_t;

endpackage

// ==== design/div_op_pkg.sv ====
/*
 * Operation encoding, request struct, sign/exception flags and the
 * control FSM states of the divide unit.
 */
package div_op_pkg;

    // low two bits of the M-extension funct3 for the divide group
    typedef enum logic [1:0] {
        DIV  = 2'b00,  // signed quotient
        DIVU = 2'b01,  // unsigned quotient
        REM  = 2'b10,  // signed remainder
        REMU = 2'b11   // unsigned remainder
    } div_op_t;

    // request as presented by the execute stage
    typedef struct packed {
        div_op_t             op;
        div_data_pkg::word_t dividend;  // rs1
        div_data_pkg::word_t divisor;   // rs2
    } div_req_t;

    // per-division fixup information, captured at start
    typedef struct packed {
        logic neg_quot;  // operand signs differ on a signed op
        logic neg_rem;   // dividend negative on a signed op
        logic div_zero;  // divisor == 0
        logic overflow;  // WORD_MIN / -1 on a signed op
    } div_flags_t;

    // top level control
    typedef enum logic [1:0] {
        IDLE,  // waiting for start
        RUN,   // core iterating
        DONE   // result held until ack
    } div_state_t;

endpackage

// ==== design/div_radix2.sv ====
/*
 * Iterative radix-2 restoring divider on unsigned magnitudes.
 * One quotient bit per cycle, complete held until ack.
 */
`timescale 1ns/1ps

module div_radix2 (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       ack,
    input  div_data_pkg::word_t        dividend,
    input  div_data_pkg::word_t        divisor,
    output div_data_pkg::core_result_t res,
    output logic                       complete
);
    import div_data_pkg::*;

    word_t           divisor_r;  // divisor held for the whole division
    word_t           quot_r;     // dividend bits leave at the top, quotient bits enter below
    word_t           rem_r;      // restored partial remainder, always < divisor
    count_t          count;      // iterations done so far
    logic            running;
    logic            iter_done;

    logic [XLEN:0]   pr_shift;   // partial remainder with next dividend bit appended
    logic [XLEN+1:0] pr_diff;    // trial subtraction, extra bit for the borrow
    logic            sub_neg;    // trial went negative, restore

    assign pr_shift  = {rem_r, quot_r[XLEN-1]};
    assign pr_diff   = {1'b0, pr_shift} - {2'b00, divisor_r};
    assign sub_neg   = pr_diff[XLEN+1];
    assign iter_done = (count == count_t'(DIV_CYCLES));

    // iteration control
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;  // operands loaded this edge
            count   <= '0;
        end else if (running) begin
            if (iter_done) begin
                running <= 1'b0;  // last step was the previous edge
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // datapath, no reset needed
    always_ff @(posedge clk) begin
        if (start) begin
            divisor_r <= divisor;
            quot_r    <= dividend;
            rem_r     <= WORD_ZERO;
        end else if (running && !iter_done) begin
            // keep the difference only when it did not borrow
            rem_r  <= sub_neg ? pr_shift[XLEN-1:0] : pr_diff[XLEN-1:0];
            quot_r <= {quot_r[XLEN-2:0], ~sub_neg};
        end
    end

    // rises one edge after the 32nd step, drops on the edge that sees ack
    always_ff @(posedge clk) begin
        if (rst) begin
            complete <= 1'b0;
        end else if (running && iter_done) begin
            complete <= 1'b1;
        end else if (ack) begin
            complete <= 1'b0;
        end
    end

    // with a zero divisor every trial succeeds: quot all ones, rem = dividend
    assign res.quot = quot_r;
    assign res.rem  = rem_r;

    // complete comes exactly DIV_CYCLES+1 edges after the start edge
    a_complete_after_start: assert property (
        @(posedge clk) disable iff (rst)
        $rose(complete) |-> $past(start, DIV_CYCLES + 2)
    ) else $error("core complete rose without a start %0d cycles earlier", DIV_CYCLES + 1);

endmodule

// ==== design/div_sign_unit.sv ====
/*
 * Operand magnitudes, result signs and special-case detection.
 * Flags and op are latched at start for the result stage.
 */
`timescale 1ns/1ps

module div_sign_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  div_op_pkg::div_req_t   req,
    output div_data_pkg::word_t    dividend_mag,
    output div_data_pkg::word_t    divisor_mag,
    output div_op_pkg::div_flags_t flags,
    output div_op_pkg::div_op_t    op
);
    import div_data_pkg::*;
    import div_op_pkg::*;

    logic       signed_op;  // DIV or REM
    logic       dvd_neg;    // dividend counts as negative
    logic       dvs_neg;    // divisor counts as negative
    div_flags_t flags_d;

    assign signed_op = (req.op == DIV) || (req.op == REM);
    assign dvd_neg   = signed_op && req.dividend[XLEN-1];
    assign dvs_neg   = signed_op && req.divisor[XLEN-1];

    // magnitudes go straight to the core in the start cycle
    // WORD_MIN maps onto itself, which is the right unsigned magnitude
    assign dividend_mag = dvd_neg ? -req.dividend : req.dividend;
    assign divisor_mag  = dvs_neg ? -req.divisor : req.divisor;

    assign flags_d.neg_quot = dvd_neg ^ dvs_neg;  // quotient truncates toward zero
    assign flags_d.neg_rem  = dvd_neg;            // remainder follows the dividend
    assign flags_d.div_zero = (req.divisor == WORD_ZERO);
    assign flags_d.overflow = signed_op
                            && (req.dividend == WORD_MIN)
                            && (req.divisor == WORD_ONES);

    // held until the next accepted start
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
            op    <= DIVU;
        end else if (start) begin
            flags <= flags_d;
            op    <= req.op;
        end
    end

    // a divisor of zero can never also be -1
    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(flags.div_zero && flags.overflow)
    ) else $error("div_zero and overflow both set");

endmodule

// ==== design/div_result_mux.sv ====
/*
 * Result stage with sign fixup of the raw core outputs, architected
 * special-case values, quotient/remainder select and output register.
 */
`timescale 1ns/1ps

module div_result_mux (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       complete,
    input  logic                       ack,
    input  div_data_pkg::core_result_t core,
    input  div_op_pkg::div_flags_t     flags,
    input  div_op_pkg::div_op_t        op,
    output div_data_pkg::word_t        result,
    output logic                       done
);
    import div_data_pkg::*;
    import div_op_pkg::*;

    word_t quot_adj;  // signed-corrected quotient
    word_t rem_adj;   // signed-corrected remainder
    word_t quot_fin;
    word_t rem_fin;
    word_t result_d;
    logic  load;      // first cycle of complete

    assign quot_adj = flags.neg_quot ? -core.quot : core.quot;
    assign rem_adj  = flags.neg_rem ? -core.rem : core.rem;

    always_comb begin
        quot_fin = quot_adj;
        rem_fin  = rem_adj;  // with div_zero this is already the original dividend
        if (flags.div_zero) begin
            quot_fin = WORD_ONES;
        end else if (flags.overflow) begin
            quot_fin = WORD_MIN;
            rem_fin  = WORD_ZERO;
        end
    end

    assign result_d = ((op == REM) || (op == REMU)) ? rem_fin : quot_fin;

    // done is still low on the edge right after complete rises
    assign load = complete && !done;

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (load) begin
            done <= 1'b1;
        end else if (ack) begin
            done <= 1'b0;  // core drops complete on the same edge
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result <= result_d;
        end
    end

    a_result_stable: assert property (
        @(posedge clk) disable iff (rst)
        done && !ack |=> done && $stable(result)
    ) else $error("result changed or done dropped before ack");

endmodule

// ==== design/div_unit.sv ====
/*
 * Divide unit top level: start gating FSM, busy, and the wiring of
 * sign unit, radix-2 core and result stage.
 */
`timescale 1ns/1ps

module div_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  div_op_pkg::div_req_t req,
    input  logic                 ack,
    output div_data_pkg::word_t  result,
    output logic                 done,
    output logic                 busy
);
    import div_data_pkg::*;
    import div_op_pkg::*;

    div_state_t   state;
    logic         start_ok;       // start accepted in IDLE only
    logic         core_complete;
    word_t        dividend_mag;
    word_t        divisor_mag;
    core_result_t core_res;
    div_flags_t   flags;
    div_op_t      op_q;           // op latched by the sign unit

    assign start_ok = start && (state == IDLE);
    assign busy     = (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start) state <= RUN;
                RUN:     if (core_complete) state <= DONE;  // same edge as done rising
                DONE:    if (ack) state <= IDLE;           // same edge as done falling
                default: state <= IDLE;
            endcase
        end
    end

    div_sign_unit sign_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start_ok),
        .req          (req),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .flags        (flags),
        .op           (op_q)
    );

    div_radix2 core_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start_ok),
        .ack      (ack),
        .dividend (dividend_mag),
        .divisor  (divisor_mag),
        .res      (core_res),
        .complete (core_complete)
    );

    div_result_mux mux_i (
        .clk      (clk),
        .rst      (rst),
        .complete (core_complete),
        .ack      (ack),
        .core     (core_res),
        .flags    (flags),
        .op       (op_q),
        .result   (result),
        .done     (done)
    );

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    ) else $error("start while busy, request dropped");

    // result stage and control FSM must agree on when the result is out
    a_done_matches_fsm: assert property (
        @(posedge clk) disable iff (rst)
        done |-> (state == DONE)
    ) else $error("done high outside the DONE state");

endmodule

// ==== dv/div_checker.sv ====
/*
 * Testbench checker for the divide unit. Compares results, start-to-done
 * latency, hold until ack, busy and reset state, and keeps the test counts.
 */
`timescale 1ns/1ps

module div_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                ack,
    input  logic                busy,
    input  logic                done,
    input  div_data_pkg::word_t result,
    input  logic [8*24-1:0]     test_name,   // name of the test being started
    input  div_data_pkg::word_t exp_result,  // its expected result
    output logic [31:0]         pass_count,
    output logic [31:0]         fail_count
);
    import div_data_pkg::*;

    localparam int DONE_LATENCY = 34;  // start edge to done edge

    int              cyc;         // rising edges seen so far
    int              start_edge;  // edge that sampled the accepted start
    int              latency;
    logic [8*24-1:0] name_q;
    word_t           exp_q;
    word_t           held;        // result as it was when done rose
    logic            active;      // a division is in flight
    logic            test_err;
    logic            rst_err;
    logic            done_q;
    logic            ack_q;
    logic            rst_q;

    initial begin
        cyc        = 0;
        pass_count = 0;
        fail_count = 0;
        active     = 1'b0;
        test_err   = 1'b0;
        rst_err    = 1'b0;
        done_q     = 1'b0;
        ack_q      = 1'b0;
        rst_q      = 1'b1;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // everything sampled at the falling edge halfway between updates
    always @(negedge clk) begin
        if (rst) begin
            if (cyc > 0 && (done !== 1'b0 || busy !== 1'b0)) begin
                rst_err = 1'b1;  // reset already applied on an edge
            end
            active = 1'b0;
        end else begin
            if (rst_q) begin
                if (rst_err) begin
                    $display("reset: done or busy was not low during reset");
                    fail_count = fail_count + 1;
                end else begin
                    $display("ok reset: done and busy low");
                    pass_count = pass_count + 1;
                end
            end
            // a test ends one cycle after the edge that took its ack
            if (active && done_q && ack_q) begin
                if (done !== 1'b0 || busy !== 1'b0) begin
                    $display("%0s: done or busy still high after ack", name_q);
                    test_err = 1'b1;
                end
                if (test_err) begin
                    fail_count = fail_count + 1;
                end else begin
                    $display("ok %0s: result %h after %0d cycles", name_q, held, latency);
                    pass_count = pass_count + 1;
                end
                active = 1'b0;
            end else if (active && done_q && !done) begin
                $display("%0s: done dropped before ack", name_q);
                fail_count = fail_count + 1;
                active     = 1'b0;
            end
            if (done && !done_q) begin
                latency = cyc - start_edge;
                held    = result;
                if (!active) begin
                    $display("done rose with no division in flight");
                    fail_count = fail_count + 1;
                end else begin
                    if (latency != DONE_LATENCY) begin
                        $display("%0s: done rose %0d cycles after start instead of %0d",
                                 name_q, latency, DONE_LATENCY);
                        test_err = 1'b1;
                    end
                    if (result !== exp_q) begin
                        $display("mismatch %0s: expected %h, actual %h", name_q, exp_q, result);
                        test_err = 1'b1;
                    end
                    if (busy !== 1'b1) begin
                        $display("%0s: busy low while the result is held", name_q);
                        test_err = 1'b1;
                    end
                end
            end else if (active && done && done_q && result !== held) begin
                $display("%0s: result changed while done was high", name_q);
                test_err = 1'b1;
            end
            if (start && !busy) begin  // same condition the DUT accepts on
                name_q     = test_name;
                exp_q      = exp_result;
                start_edge = cyc + 1;
                active     = 1'b1;
                test_err   = 1'b0;
            end
        end
        done_q = done;
        ack_q  = ack;
        rst_q  = rst;
    end

endmodule

// ==== dv/div_unit_tb.sv ====
/*
 * Divide unit testbench: clock, reset, pattern file reader,
 * request driver with random ack delay, timeout and verdict.
 */
`timescale 1ns/1ps

module div_unit_tb;
    import div_data_pkg::*;
    import div_op_pkg::*;

    localparam int MAX_PAT   = 64;
    localparam int NAME_BITS = 8*24;  // up to 24 characters per test name

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic                 ack;
    div_req_t             req;
    word_t                result;
    logic                 done;
    logic                 busy;
    logic [NAME_BITS-1:0] cur_name;
    word_t                cur_exp;
    logic [31:0]          pass_count;
    logic [31:0]          fail_count;

    logic [NAME_BITS-1:0] pat_name [MAX_PAT];
    div_op_t              pat_op   [MAX_PAT];
    word_t                pat_dvd  [MAX_PAT];
    word_t                pat_dvs  [MAX_PAT];
    word_t                pat_exp  [MAX_PAT];
    int                   n_pat;
    logic                 load_ok;
    int                   cycles;  // timeout counter
    int                   limit;
    int                   seed;
    int                   rnd;

    always #10 clk = ~clk;

    div_unit dut_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .req    (req),
        .ack    (ack),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    div_checker chk_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .ack        (ack),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .test_name  (cur_name),
        .exp_result (cur_exp),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // op mnemonic as written in the pattern file
    task automatic decode_op(input logic [63:0] txt, output div_op_t op, output logic ok);
        ok = 1'b1;
        op = DIVU;
        case (txt)
            "DIV":   op = DIV;
            "DIVU":  op = DIVU;
            "REM":   op = REM;
            "REMU":  op = REMU;
            default: ok = 1'b0;
        endcase
    endtask

    task automatic load_patterns();
        int                   fd;
        int                   code;
        logic [NAME_BITS-1:0] tok;
        logic [63:0]          op_txt;
        logic [8*128-1:0]     skip;
        div_op_t              op;
        logic                 op_ok;
        word_t                dvd;
        word_t                dvs;
        word_t                exp_v;
        n_pat   = 0;
        load_ok = 1'b1;
        fd = $fopen("dv/div_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/div_patterns.txt");
            load_ok = 1'b0;
        end else begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(skip, fd);  // drop the rest of a comment line
                end else begin
                    code = $fscanf(fd, "%s %h %h %h", op_txt, dvd, dvs, exp_v);
                    decode_op(op_txt, op, op_ok);
                    if (code != 4 || !op_ok || n_pat == MAX_PAT) begin
                        $display("pattern %0s could not be read", tok);
                        load_ok = 1'b0;
                    end else begin
                        pat_name[n_pat] = tok;
                        pat_op[n_pat]   = op;
                        pat_dvd[n_pat]  = dvd;
                        pat_dvs[n_pat]  = dvs;
                        pat_exp[n_pat]  = exp_v;
                        n_pat           = n_pat + 1;
                    end
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        if (n_pat == 0) begin
            $display("no patterns were loaded");
            load_ok = 1'b0;
        end
    endtask

    // called 2 ns after an edge, leaves 2 ns after the edge that took the ack
    task automatic run_pattern(input int i);
        int ack_wait;
        cur_name     = pat_name[i];
        cur_exp      = pat_exp[i];
        req.op       = pat_op[i];
        req.dividend = pat_dvd[i];
        req.divisor  = pat_dvs[i];
        start        = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (!done);
        ack_wait = $urandom % 4;  // 0 to 3 cycles of back-pressure
        repeat (ack_wait) begin
            @(posedge clk);
            #2;
        end
        ack = 1'b1;
        @(posedge clk);
        #2;
        ack = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: no end of run after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        ack      = 1'b0;
        req      = '0;
        cur_name = '0;
        cur_exp  = '0;
        cycles   = 0;
        seed     = 94296;
        rnd      = $urandom(seed);  // seeds the ack delays
        load_patterns();
        limit = n_pat * 40 + 100;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < n_pat; i++) begin
            run_pattern(i);  // next start goes out right after the ack
        end
        @(negedge clk);  // checker closes the last test here
        #1;
        if (pass_count + fail_count != n_pat + 1) begin
            $display("only %0d of %0d tests completed", pass_count + fail_count, n_pat + 1);
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (load_ok && fail_count == 0 && pass_count == n_pat + 1) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/div_patterns.txt ====
# columns: name, op (DIV DIVU REM REMU), dividend, divisor, expected result
# numbers in hex; the expected result is the quotient or remainder that op selects
divu_basic      DIVU 00000064 00000007 0000000e
remu_basic      REMU 00000064 00000007 00000002
divu_max_by1    DIVU ffffffff 00000001 ffffffff
remu_max_by1    REMU ffffffff 00000001 00000000
divu_max_big    DIVU ffffffff 0000ffff 00010001
remu_small_big  REMU 00000005 80000000 00000005
divu_min_ones   DIVU 80000000 ffffffff 00000000
div_pos_pos     DIV  00000007 00000002 00000003
div_neg_pos     DIV  fffffff9 00000002 fffffffd
div_pos_neg     DIV  00000007 fffffffe fffffffd
div_neg_neg     DIV  fffffff9 fffffffe 00000003
rem_pos_pos     REM  00000007 00000002 00000001
rem_neg_pos     REM  fffffff9 00000002 ffffffff
rem_pos_neg     REM  00000007 fffffffe 00000001
rem_neg_neg     REM  fffffff9 fffffffe ffffffff
div_min_by2     DIV  80000000 00000002 c0000000
div_min_by3     DIV  80000000 00000003 d5555556
rem_min_by3     REM  80000000 00000003 fffffffe
divu_zero       DIVU 12345678 00000000 ffffffff
remu_zero       REMU 12345678 00000000 12345678
div_zero        DIV  87654321 00000000 ffffffff
rem_zero        REM  87654321 00000000 87654321
div_ovf         DIV  80000000 ffffffff 80000000
rem_ovf         REM  80000000 ffffffff 00000000
divu_after_ovf  DIVU 00000064 00000007 0000000e

// ==== files.f ====
design/div_data_pkg.sv
design/div_op_pkg.sv
design/div_radix2.sv
design/div_sign_unit.sv
design/div_result_mux.sv
design/div_unit.sv
dv/div_checker.sv
dv/div_unit_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - files:
      - design/div_data_pkg.sv
      - design/div_op_pkg.sv
      - design/div_radix2.sv
      - design/div_sign_unit.sv
      - design/div_result_mux.sv
      - design/div_unit.sv
  - target: simulation
    files:
      - dv/div_checker.sv
      - dv/div_unit_tb.sv
